/* include/mem_main_consts.svh */
`ifndef MEM_MAIN_CONSTS_SVH
`define MEM_MAIN_CONSTS_SVH

// requester side
`define MM_NUM_RT       4
`define MM_CREDITS      4   // also the request queue depth

// memory geometry
`define MM_NUM_THREAD   4
`define MM_ROW_AW       8   // rows per bank = 2**MM_ROW_AW

// byte address layout
// word index starts at bit 2 and is MM_ROW_AW+2 bits wide
`define MM_THREAD_LSB   16
`define MM_THREAD_W     2

`endif

/* logic/mem_main_pkg.sv */
`default_nettype none

`include "mem_main_consts.svh"

package mem_main_pkg;

    typedef enum logic {
        MM_OP_READ  = 1'b0,
        MM_OP_WRITE = 1'b1
    } mm_op_e;

    // request as issued by an RT port, 161 bits
    typedef struct packed {
        mm_op_e         op;
        logic [31:0]    addr;   // byte address
        logic [127:0]   data;   // lane k at bits 32k+31:32k
    } mm_req_t;

    typedef struct packed {
        logic [127:0]   line;
    } mm_rsp_t;

    // granted request on its way into one thread's banks
    typedef struct packed {
        mm_op_e                         op;
        logic [$clog2(`MM_NUM_RT)-1:0]  port;
        logic [`MM_ROW_AW+1:0]          widx;   // word index of lane 0
        logic [127:0]                   data;
    } mm_bank_cmd_t;

endpackage

`default_nettype wire

/* logic/single_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_main_consts.svh"

module single_port_ram (
    input  wire logic                   clk,
    input  wire logic                   we,
    input  wire logic [`MM_ROW_AW-1:0]  addr,
    input  wire logic [31:0]            data,
    output logic [31:0]                 q
);

    logic [31:0] mem [0:(1 << `MM_ROW_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];     // old data on a same-cycle write
    end

endmodule

`default_nettype wire

/* logic/rt_port_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_main_consts.svh"

module rt_port_queue (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   req_valid,
    input  wire mem_main_pkg::mm_req_t  req,
    input  wire logic                   pop,
    output logic                        head_valid,
    output mem_main_pkg::mm_req_t       head,
    output logic                        credit_return
);

    import mem_main_pkg::*;

    localparam int DEPTH = `MM_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mm_req_t            slots [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(DEPTH));
    assign head_valid = (count != '0);
    assign head       = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            slots[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;   // one credit per departed request
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // requester pushed without holding a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> !req_valid);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

endmodule

`default_nettype wire

/* logic/thread_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_main_consts.svh"

module thread_arbiter #(
    parameter int THREAD_ID = 0
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`MM_NUM_RT-1:0]      head_valid,
    input  wire mem_main_pkg::mm_req_t      head [`MM_NUM_RT],
    output logic [`MM_NUM_RT-1:0]           grant,
    output logic                            cmd_valid,
    output mem_main_pkg::mm_bank_cmd_t      cmd
);

    import mem_main_pkg::*;

    localparam int NUM = `MM_NUM_RT;
    localparam int PW  = (NUM > 1) ? $clog2(NUM) : 1;
    localparam int TW  = `MM_THREAD_W;
    localparam int WW  = `MM_ROW_AW + 2;

    logic [NUM-1:0] match;
    logic [PW-1:0]  ptr;    // highest priority port this cycle
    logic [PW-1:0]  win;
    logic           any;

    always_comb begin
        for (int p = 0; p < NUM; p++) begin
            match[p] = head_valid[p] &&
                       (head[p].addr[`MM_THREAD_LSB +: TW] == TW'(THREAD_ID));
        end
    end

    // first match at or after ptr, wrapping
    always_comb begin
        int idx;
        win = ptr;
        any = 1'b0;
        for (int k = 0; k < NUM; k++) begin
            idx = (int'(ptr) + k) % NUM;
            if (!any && match[idx]) begin
                any = 1'b1;
                win = PW'(idx);
            end
        end
    end

    always_comb begin
        grant      = '0;
        grant[win] = any;
    end

    assign cmd_valid = any;

    always_comb begin
        cmd.op   = head[win].op;
        cmd.port = win;
        cmd.widx = head[win].addr[2 +: WW];
        cmd.data = head[win].data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (any) begin
            ptr <= (win == PW'(NUM - 1)) ? '0 : win + 1'b1;
        end
    end

    // a head that loses arbitration stays at the queue head
    for (genvar p = 0; p < NUM; p++) begin : g_chk
        a_hold_head: assert property (@(posedge clk) disable iff (!rst_n)
            (match[p] && !grant[p]) |=> (match[p] && $stable(head[p])));
    end

endmodule

`default_nettype wire

/* logic/thread_bank_group.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_main_consts.svh"

module thread_bank_group (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           cmd_valid,
    input  wire mem_main_pkg::mm_bank_cmd_t     cmd,
    output logic                                rsp_valid,
    output logic [$clog2(`MM_NUM_RT)-1:0]       rsp_port,
    output mem_main_pkg::mm_rsp_t               rsp
);

    import mem_main_pkg::*;

    localparam int NB = 4;      // one bank per word lane
    localparam int PW = $clog2(`MM_NUM_RT);
    localparam int RW = `MM_ROW_AW;
    localparam int WW = RW + 2;

    logic [1:0]     n_lo;
    logic [RW-1:0]  s1_row [NB];
    logic [31:0]    s1_data [NB];
    logic           s1_valid;
    mm_op_e         s1_op;
    logic [PW-1:0]  s1_port;
    logic [1:0]     s1_lo;
    logic           s2_valid;
    logic [PW-1:0]  s2_port;
    logic [1:0]     s2_lo;
    logic           bank_we;
    logic [31:0]    bank_q [NB];

    assign n_lo    = cmd.widx[1:0];
    assign bank_we = s1_valid && (s1_op == MM_OP_WRITE);

    for (genvar j = 0; j < NB; j++) begin : g_bank
        logic [1:0]     lane;   // which request lane lands in bank j
        logic [WW-1:0]  widx_j;

        assign lane   = 2'(j) - n_lo;
        assign widx_j = cmd.widx + WW'(lane);   // row wraps with the bank depth

        always_ff @(posedge clk) begin
            if (cmd_valid) begin
                s1_row[j]  <= widx_j[WW-1:2];
                s1_data[j] <= cmd.data[32*lane +: 32];
            end
        end

        single_port_ram i_ram (
            .clk  (clk),
            .we   (bank_we),
            .addr (s1_row[j]),
            .data (s1_data[j]),
            .q    (bank_q[j])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= cmd_valid;
            s2_valid  <= s1_valid && (s1_op == MM_OP_READ);   // writes stop here
            rsp_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op   <= cmd.op;
        s1_port <= cmd.port;
        s1_lo   <= n_lo;
        s2_port <= s1_port;
        s2_lo   <= s1_lo;
        if (s2_valid) begin
            rsp_port <= s2_port;
            // back into lane order
            for (int k = 0; k < NB; k++) begin
                rsp.line[32*k +: 32] <= bank_q[s2_lo + 2'(k)];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mem_main.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_main_consts.svh"

module mem_main (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`MM_NUM_RT-1:0]  req_valid,
    input  wire mem_main_pkg::mm_req_t  req [`MM_NUM_RT],
    output logic [`MM_NUM_RT-1:0]       credit_return,
    output logic [`MM_NUM_RT-1:0]       rsp_valid,
    output mem_main_pkg::mm_rsp_t       rsp [`MM_NUM_RT]
);

    import mem_main_pkg::*;

    localparam int NUM = `MM_NUM_RT;
    localparam int NT  = `MM_NUM_THREAD;
    localparam int PW  = $clog2(NUM);

    logic [NUM-1:0] head_valid;
    mm_req_t        head [NUM];
    logic [NUM-1:0] pop;
    logic [NUM-1:0] grant [NT];
    logic [NT-1:0]  cmd_valid;
    mm_bank_cmd_t   cmd [NT];
    logic [NT-1:0]  grp_rsp_valid;
    logic [PW-1:0]  grp_rsp_port [NT];
    mm_rsp_t        grp_rsp [NT];
    logic [NT-1:0]  port_hit [NUM];    // bank groups answering each port

    for (genvar p = 0; p < NUM; p++) begin : g_port
        rt_port_queue i_queue (
            .clk           (clk),
            .rst_n         (rst_n),
            .req_valid     (req_valid[p]),
            .req           (req[p]),
            .pop           (pop[p]),
            .head_valid    (head_valid[p]),
            .head          (head[p]),
            .credit_return (credit_return[p])
        );
    end

    for (genvar t = 0; t < NT; t++) begin : g_thread
        thread_arbiter #(.THREAD_ID(t)) i_arb (
            .clk        (clk),
            .rst_n      (rst_n),
            .head_valid (head_valid),
            .head       (head),
            .grant      (grant[t]),
            .cmd_valid  (cmd_valid[t]),
            .cmd        (cmd[t])
        );

        thread_bank_group i_group (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd_valid (cmd_valid[t]),
            .cmd       (cmd[t]),
            .rsp_valid (grp_rsp_valid[t]),
            .rsp_port  (grp_rsp_port[t]),
            .rsp       (grp_rsp[t])
        );
    end

    // a head matches one thread only, so at most one arbiter pops it
    always_comb begin
        pop = '0;
        for (int t = 0; t < NT; t++) begin
            pop = pop | grant[t];
        end
    end

    always_comb begin
        for (int p = 0; p < NUM; p++) begin
            for (int t = 0; t < NT; t++) begin
                port_hit[p][t] = grp_rsp_valid[t] && (grp_rsp_port[t] == PW'(p));
            end
        end
    end

    always_comb begin
        rsp_valid = '0;
        for (int p = 0; p < NUM; p++) begin
            rsp[p] = '0;
            for (int t = 0; t < NT; t++) begin
                if (port_hit[p][t]) begin
                    rsp_valid[p] = 1'b1;
                    rsp[p]       = grp_rsp[t];
                end
            end
        end
    end

    for (genvar p = 0; p < NUM; p++) begin : g_chk
        a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(port_hit[p]));
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_main.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_main_consts.svh"

module tb_mem_main;

    import mem_main_pkg::*;

    localparam int NUM     = `MM_NUM_RT;
    localparam int NT      = `MM_NUM_THREAD;
    localparam int CREDITS = `MM_CREDITS;
    localparam int WORDS   = 1 << (`MM_ROW_AW + 2);   // words per thread
    localparam int REGION  = WORDS / NUM;             // words owned by one port

    logic               clk = 1'b0;
    logic               rst_n = 1'b0;
    logic [NUM-1:0]     req_valid;
    mm_req_t            req [NUM];
    logic [NUM-1:0]     credit_return;
    logic [NUM-1:0]     rsp_valid;
    mm_rsp_t            rsp [NUM];

    int                 credits [NUM];
    mm_req_t            pend_q [NUM][$];    // waiting for a credit
    logic [127:0]       exp_q [NUM][$];     // expected read lines in issue order
    logic [31:0]        model [NT][WORDS];
    bit                 known [NT][WORDS];
    logic [31:0]        rng_state = 32'he462;
    logic               quiet = 1'b0;

    mem_main i_mem_main (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

    always #2 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [127:0] rand_line();
        logic [127:0] l;
        for (int k = 0; k < 4; k++) begin
            l[32*k +: 32] = rand32();
        end
        return l;
    endfunction

    function automatic logic [31:0] make_addr(input int t, input int w);
        logic [31:0] a;
        a = '0;
        a[`MM_THREAD_LSB +: `MM_THREAD_W] = t[`MM_THREAD_W-1:0];
        a[2 +: `MM_ROW_AW+2] = w[`MM_ROW_AW+1:0];
        return a;
    endfunction

    function automatic bit line_known(input int t, input int w);
        bit ok;
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            if (!known[t][(w + k) % WORDS]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic bit all_idle();
        bit idle;
        idle = 1'b1;
        for (int p = 0; p < NUM; p++) begin
            if (pend_q[p].size() != 0 || exp_q[p].size() != 0 || credits[p] != CREDITS) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    function automatic bit all_sent();
        bit sent;
        sent = 1'b1;
        for (int p = 0; p < NUM; p++) begin
            if (pend_q[p].size() != 0) begin
                sent = 1'b0;
            end
        end
        return sent;
    endfunction

    // the model changes when the write is queued
    // lanes wrap at the thread size
    task automatic queue_write(input int p, input int t, input int w, input logic [127:0] d);
        mm_req_t r;
        for (int k = 0; k < 4; k++) begin
            model[t][(w + k) % WORDS] = d[32*k +: 32];
            known[t][(w + k) % WORDS] = 1'b1;
        end
        r.op   = MM_OP_WRITE;
        r.addr = make_addr(t, w);
        r.data = d;
        pend_q[p].push_back(r);
    endtask

    task automatic queue_read(input int p, input int t, input int w);
        mm_req_t        r;
        logic [127:0]   line;
        for (int k = 0; k < 4; k++) begin
            line[32*k +: 32] = model[t][(w + k) % WORDS];
        end
        r.op   = MM_OP_READ;
        r.addr = make_addr(t, w);
        r.data = '0;
        exp_q[p].push_back(line);
        pend_q[p].push_back(r);
    endtask

    task automatic wait_sent(input int limit);
        int n;
        n = 0;
        while (!all_sent()) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                fail_now($sformatf("timeout at %0t: requests never got a credit", $time));
            end
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!all_idle()) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                fail_now($sformatf("timeout at %0t: credits or responses still missing", $time));
            end
        end
    endtask

    // one request per port per falling edge while a credit is held
    initial begin
        req_valid = '0;
        for (int p = 0; p < NUM; p++) begin
            req[p] = '0;
        end
        forever begin
            @(negedge clk);
            for (int p = 0; p < NUM; p++) begin
                if (rst_n && pend_q[p].size() > 0 && credits[p] > 0) begin
                    req[p]       = pend_q[p].pop_front();
                    req_valid[p] = 1'b1;
                end else begin
                    req_valid[p] = 1'b0;
                end
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM; p++) begin
                credits[p] <= CREDITS;
            end
        end else begin
            for (int p = 0; p < NUM; p++) begin
                credits[p] <= credits[p] + (credit_return[p] ? 1 : 0) - (req_valid[p] ? 1 : 0);
            end
        end
    end

    always @(posedge clk) begin
        logic [127:0] want;
        if (rst_n) begin
            for (int p = 0; p < NUM; p++) begin
                if (rsp_valid[p]) begin
                    assert (exp_q[p].size() > 0) else fail_now($sformatf(
                        "error at %0t: port %0d got a response with no read pending",
                        $time, p));
                    want = exp_q[p].pop_front();
                    assert (rsp[p].line == want) else fail_now($sformatf(
                        "error at %0t: port %0d read %h, expected %h",
                        $time, p, rsp[p].line, want));
                end
            end
        end
    end

    a_quiet: assert property (@(posedge clk) quiet |-> (rsp_valid == '0 && credit_return == '0))
        else fail_now($sformatf("error at %0t: output active before any request", $time));

    for (genvar p = 0; p < NUM; p++) begin : g_credit_chk
        a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
            credit_return[p] |-> (credits[p] < CREDITS))
            else fail_now($sformatf("error at %0t: port %0d got an extra credit", $time, p));
    end

    initial begin
        int             p;
        int             t;
        int             w;
        logic [31:0]    r;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset
        quiet = 1'b1;
        repeat (12) @(posedge clk);
        quiet = 1'b0;

        // aligned round trips
        queue_write(0, 0, 8, rand_line());
        queue_read(0, 0, 8);
        queue_write(3, 3, 3 * REGION + 100, rand_line());
        queue_read(3, 3, 3 * REGION + 100);
        wait_idle(200);

        // unaligned lines that straddle two rows
        for (int off = 1; off < 4; off++) begin
            w = REGION + 16 * off + off;
            queue_write(1, 1, w, rand_line());
            queue_read(1, 1, w);
        end
        queue_write(1, 1, REGION + 80, rand_line());
        queue_write(1, 1, REGION + 84, rand_line());
        for (int off = 1; off < 4; off++) begin
            queue_read(1, 1, REGION + 80 + off);
        end
        wait_idle(300);

        // all ports on thread 2 in the same cycle
        for (p = 0; p < NUM; p++) begin
            queue_write(p, 2, p * REGION + 40 + p, rand_line());
            queue_write(p, 2, p * REGION + 44 + p, rand_line());
            queue_read(p, 2, p * REGION + 40 + p);
            queue_read(p, 2, p * REGION + 41 + p);
        end
        wait_idle(300);

        // twice the credit count per port on thread 0 so the queues fill up
        for (int k = 0; k < 2 * CREDITS; k++) begin
            for (p = 0; p < NUM; p++) begin
                if (k % 2 == 0) begin
                    queue_write(p, 0, p * REGION + 120 + k, rand_line());
                end else begin
                    queue_read(p, 0, p * REGION + 119 + k);
                end
            end
        end
        wait_idle(500);

        // random traffic inside each port's own word range
        for (int i = 0; i < 300; i++) begin
            r = rand32();
            p = int'(r[3:0]) % NUM;
            t = int'(r[7:4]) % NT;
            w = p * REGION + int'(r[23:8]) % (REGION - 3);
            if (r[24] && line_known(t, w)) begin
                queue_read(p, t, w);
            end else begin
                queue_write(p, t, w, rand_line());
            end
            if (r[27:25] == 3'd0) begin
                wait_sent(200);   // lets the queues drain now and then
            end
        end
        wait_idle(5000);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* mem_main.f */
+incdir+include
logic/mem_main_pkg.sv
logic/single_port_ram.sv
logic/rt_port_queue.sv
logic/thread_arbiter.sv
logic/thread_bank_group.sv
logic/mem_main.sv
testbench/tb_mem_main.sv

/* run_sim.sh */
#!/bin/sh
# compile and run tb_mem_main with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_main -f mem_main.f -o vsim || exit 1
./obj_dir/vsim > sim.log 2>&1 || echo "simulation ended with a non-zero status" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "result: run did not complete"; exit 1; }
echo "result: pass"
